/* pingpong_ctrl.f */
rtl/pingpong_pkg.sv
rtl/buf_phase_fsm.sv
rtl/write_addr_gen.sv
rtl/read_tile_seq.sv
rtl/pingpong_ctrl_top.sv
verif/pingpong_assertions.sv
verif/pingpong_tb.sv

/* Bender.yml */
package:
  name: pingpong_ctrl

sources:
  # Design, package first
  - files:
      - rtl/pingpong_pkg.sv
      - rtl/buf_phase_fsm.sv
      - rtl/write_addr_gen.sv
      - rtl/read_tile_seq.sv
      - rtl/pingpong_ctrl_top.sv

  # Testbench and bound checks
  - target: test
    files:
      - verif/pingpong_assertions.sv
      - verif/pingpong_tb.sv

/* verif/pingpong_tb.sv */
//////////////////////////////
// Directed testbench for the ping-pong buffer controller
// Runs load bursts, reads and completion against the top level
//////////////////////////////

module pingpong_tb
    import pingpong_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Default geometry, words per half bank and blocks per row
    localparam int W_COL  = 4;
    localparam int BLOCKS = 2;

    logic clk = 1'b0;
    logic rst_n, in_valid, step, acc_done, out_valid, busy;
    west_bank_t  w_bank0, w_bank1;
    north_bank_t n_bank;
    int errors = 0;
    int tests  = 0;
    int failed = 0;
    logic [31:0] rng = 32'h3a29;

    pingpong_ctrl_top dut_i (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .step(step),
        .acc_done(acc_done), .w_bank0(w_bank0), .w_bank1(w_bank1),
        .n_bank(n_bank), .out_valid(out_valid), .busy(busy)
    );

    bind pingpong_ctrl_top pingpong_assertions assertions_i (
        .clk(clk), .rst_n(rst_n), .state(state), .w_bank0(w_bank0),
        .w_bank1(w_bank1), .n_bank(n_bank), .out_valid(out_valid)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_west(input string name, input west_bank_t got, input west_bank_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_north(input string name, input north_bank_t got, input north_bank_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors > errs_before) begin
            failed++;
            $display("test %s: FAIL", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // One load burst, beats checked on the falling edge after each write edge
    task automatic load_burst(input logic to_bank1, input int n_base, input int n_rd);
        west_bank_t wr_port;
        west_bank_t idle_port;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        for (int k = 0; k < W_COL; k++) begin
            wr_port   = to_bank1 ? w_bank1 : w_bank0;
            idle_port = to_bank1 ? w_bank0 : w_bank1;
            check_west("write bank", wr_port,
                       west_bank_t'{1'b1, 1'b1, 1'b1, w_addr_t'(k), w_addr_t'(W_COL + k)});
            check_bit("idle bank we", idle_port.we_a | idle_port.we_b, 1'b0);
            check_north("n_bank", n_bank,
                        north_bank_t'{1'b1, 1'b1, n_addr_t'(n_base + k), n_addr_t'(n_rd)});
            @(negedge clk);
        end
        // Burst over, phase swapped
        check_bit("n_bank.we", n_bank.we, 1'b0);
        check_bit("busy", busy, 1'b1);
    endtask

    // Rising acc_done edge, held for a random number of cycles
    task automatic acc_pulse();
        int gap;
        acc_done = 1'b1;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b1);
        rng = xorshift32(rng);
        gap = 1 + int'(rng % 3);
        repeat (gap) begin
            @(negedge clk);
            check_bit("out_valid", out_valid, 1'b0);
        end
        acc_done = 1'b0;
        @(negedge clk);
        check_bit("out_valid", out_valid, 1'b0);
    endtask

    task automatic reset_values();
        int e0 = errors;
        // Bank 0 holds the idle write port, resting at 0 and W_COL
        check_west("w_bank0", w_bank0,
                   west_bank_t'{1'b1, 1'b0, 1'b0, 4'd0, w_addr_t'(W_COL)});
        check_west("w_bank1", w_bank1, west_bank_t'{1'b1, 1'b0, 1'b0, 4'd0, 4'd0});
        check_north("n_bank", n_bank, north_bank_t'{1'b1, 1'b0, 4'd0, 4'd0});
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        finish_test("reset", e0);
    endtask

    // Bank 0 is readable while bank 1 waits for its load
    task automatic read_walk();
        int e0 = errors;
        for (int col = 0; col < 2; col++) begin
            for (int c = 0; c < BLOCKS; c++) begin
                step = 1'b1;
                @(negedge clk);
                step = 1'b0;
                check_west("w_bank0", w_bank0,
                           west_bank_t'{1'b1, 1'b0, 1'b0, w_addr_t'(c), w_addr_t'(BLOCKS + c)});
                check_north("n_bank", n_bank,
                            north_bank_t'{1'b1, 1'b0, 4'd4, n_addr_t'(c + BLOCKS * col)});
            end
            acc_pulse();
        end
        finish_test("reads", e0);
    endtask

    task automatic finish_tiles();
        int e0 = errors;
        int i = 0;
        acc_pulse();
        acc_pulse();
        while (w_bank0.en && i < 20) begin
            @(negedge clk);
            i++;
        end
        if (w_bank0.en) begin
            errors++;
            $display("Timeout: banks still enabled after the last output element");
        end
        check_bit("w_bank1.en", w_bank1.en, 1'b0);
        check_bit("n_bank.en", n_bank.en, 1'b0);
        check_bit("busy", busy, 1'b0);
        // A late load must be ignored
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        repeat (6) begin
            check_bit("any we", w_bank0.we_a | w_bank0.we_b | w_bank1.we_a |
                      w_bank1.we_b | n_bank.we, 1'b0);
            @(negedge clk);
        end
        finish_test("completion", e0);
    endtask

    initial begin
        int e0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        step     = 1'b0;
        acc_done = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_values();
        e0 = errors;
        load_burst(1'b0, 0, 0);
        finish_test("first_burst", e0);
        read_walk();
        e0 = errors;
        load_burst(1'b1, 4, 3);
        finish_test("phase_swap", e0);
        finish_tiles();
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests, failed, errors, dut_i.assertions_i.fail_count);
        if (errors == 0 && dut_i.assertions_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verif/pingpong_assertions.sv */
//////////////////////////////
// Concurrent checks for the ping-pong controller
// Bound into the top level by the testbench
//////////////////////////////

module pingpong_assertions
    import pingpong_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input buf_state_e  state,
    input west_bank_t  w_bank0,
    input west_bank_t  w_bank1,
    input north_bank_t n_bank,
    input logic        out_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // Running count of failed properties
    int fail_count = 0;

    // Only one west bank may be in its write phase
    west_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !((w_bank0.we_a || w_bank0.we_b) && (w_bank1.we_a || w_bank1.we_b)))
        else begin
            $error("both west banks written in the same cycle");
            fail_count++;
        end

    // Nothing is written once the run is over
    no_write_when_done: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_DONE) |-> !(w_bank0.we_a || w_bank0.we_b || w_bank1.we_a ||
                                 w_bank1.we_b || n_bank.we))
        else begin
            $error("write enable high in done state");
            fail_count++;
        end

    // Output strobe is a single cycle
    out_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else begin
            $error("out_valid held for two cycles");
            fail_count++;
        end

endmodule

/* rtl/pingpong_ctrl_top.sv */
//////////////////////////////
// Top level of the ping-pong buffer controller
// Steers write and read addresses onto the two west banks and the north bank
//////////////////////////////

module pingpong_ctrl_top
    import pingpong_pkg::*;
#(
    parameter int W_COL          = 4,
    parameter int N_ROW          = 4,
    parameter int N_COL          = 4,
    parameter int INNER_DIM      = 4,
    parameter int COL_Y          = 2,
    parameter int MAX_TILES      = 4,
    parameter int BEATS_PER_LOAD = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic        step,
    input  logic        acc_done,
    output west_bank_t  w_bank0,
    output west_bank_t  w_bank1,
    output north_bank_t n_bank,
    output logic        out_valid,
    output logic        busy
);

    buf_state_e state;
    logic       bank_full;
    cnt_t       north_cols_ready;
    cnt_t       tile_done_cnt;
    west_bank_t w_wr0;
    west_bank_t w_wr1;
    west_bank_t w_rd;
    west_bank_t w_sel0;
    west_bank_t w_sel1;
    logic       n_we;
    n_addr_t    n_wr_addr;
    n_addr_t    n_rd_addr;
    logic       bank_en;

    buf_phase_fsm #(
        .MAX_TILES (MAX_TILES)
    ) fsm_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .bank_full     (bank_full),
        .tile_done_cnt (tile_done_cnt),
        .state         (state)
    );

    write_addr_gen #(
        .W_COL          (W_COL),
        .N_ROW          (N_ROW),
        .N_COL          (N_COL),
        .INNER_DIM      (INNER_DIM),
        .BEATS_PER_LOAD (BEATS_PER_LOAD)
    ) wr_gen_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .state            (state),
        .w_wr0            (w_wr0),
        .w_wr1            (w_wr1),
        .n_we             (n_we),
        .n_wr_addr        (n_wr_addr),
        .bank_full        (bank_full),
        .north_cols_ready (north_cols_ready)
    );

    read_tile_seq #(
        .INNER_DIM (INNER_DIM),
        .COL_Y     (COL_Y),
        .MAX_TILES (MAX_TILES)
    ) rd_seq_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .state            (state),
        .bank_full        (bank_full),
        .step             (step),
        .acc_done         (acc_done),
        .north_cols_ready (north_cols_ready),
        .w_rd             (w_rd),
        .n_rd_addr        (n_rd_addr),
        .out_valid        (out_valid),
        .tile_done_cnt    (tile_done_cnt)
    );

    // Banks stay enabled until the run is over
    assign bank_en = (state != ST_DONE);
    assign busy    = (state == ST_W0_R1) || (state == ST_W1_R0);

    // Bank 0 reads only in ST_W1_R0, bank 1 reads otherwise
    assign w_sel0 = (state == ST_W1_R0) ? w_rd : w_wr0;
    assign w_sel1 = (state == ST_W1_R0) ? w_wr1 : w_rd;

    assign w_bank0 = '{en: bank_en, we_a: w_sel0.we_a, we_b: w_sel0.we_b,
                       addr_a: w_sel0.addr_a, addr_b: w_sel0.addr_b};
    assign w_bank1 = '{en: bank_en, we_a: w_sel1.we_a, we_b: w_sel1.we_b,
                       addr_a: w_sel1.addr_a, addr_b: w_sel1.addr_b};

    // Single north bank, separate write and read ports
    assign n_bank = '{en: bank_en, we: n_we, wr_addr: n_wr_addr, rd_addr: n_rd_addr};

endmodule

/* rtl/read_tile_seq.sv */
//////////////////////////////
// Result stage of the ping-pong controller
// Steps read addresses on each array strobe and counts output elements
//////////////////////////////

module read_tile_seq
    import pingpong_pkg::*;
#(
    parameter int INNER_DIM = 4,
    parameter int COL_Y     = 2,
    parameter int MAX_TILES = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  buf_state_e state,
    input  logic       bank_full,
    input  logic       step,
    input  logic       acc_done,
    input  cnt_t       north_cols_ready,
    output west_bank_t w_rd,
    output n_addr_t    n_rd_addr,
    output logic       out_valid,
    output cnt_t       tile_done_cnt
);

    localparam int BLOCKS = INNER_DIM / BLOCK_SIZE;

    logic    rd_valid;
    logic    running;
    logic    step_ok;
    logic    acc_d;
    logic    acc_rise;
    logic    bank_released;
    cnt_t    blk_cnt;
    cnt_t    col_cnt;
    w_addr_t rd_addr_a;
    w_addr_t rd_addr_b;

    assign running  = (state == ST_W0_R1) || (state == ST_W1_R0);
    assign acc_rise = acc_done && !acc_d;

    // Step counts only once the needed north columns have arrived
    assign step_ok = step && rd_valid && running && (north_cols_ready >= col_cnt);

    // Last column of the read bank is done
    assign bank_released = acc_rise && (col_cnt == cnt_t'(COL_Y - 1));

    // Read port, no write enables
    assign w_rd.en     = rd_valid;
    assign w_rd.we_a   = 1'b0;
    assign w_rd.we_b   = 1'b0;
    assign w_rd.addr_a = rd_addr_a;
    assign w_rd.addr_b = rd_addr_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid      <= 1'b0;
            acc_d         <= 1'b0;
            out_valid     <= 1'b0;
            blk_cnt       <= '0;
            col_cnt       <= '0;
            tile_done_cnt <= '0;
            rd_addr_a     <= '0;
            rd_addr_b     <= '0;
            n_rd_addr     <= '0;
        end else begin
            acc_d     <= acc_done;
            out_valid <= acc_rise;

            // A freshly filled bank wins over a release in the same cycle
            if (bank_full) begin
                rd_valid <= 1'b1;
            end else if (bank_released) begin
                rd_valid <= 1'b0;
            end

            // Block walk along the inner dimension
            if (step_ok) begin
                rd_addr_a <= w_addr_t'(blk_cnt);
                rd_addr_b <= w_addr_t'(cnt_t'(BLOCKS) + blk_cnt);
                n_rd_addr <= n_addr_t'(blk_cnt + cnt_t'(BLOCKS) * col_cnt);
                if (blk_cnt == cnt_t'(BLOCKS - 1)) begin
                    blk_cnt <= '0;
                end else begin
                    blk_cnt <= blk_cnt + 1'b1;
                end
            end

            // One output element per acc_done edge
            if (acc_rise) begin
                if (bank_released) begin
                    col_cnt <= '0;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
                // Saturates at the terminal count
                if (tile_done_cnt != cnt_t'(MAX_TILES)) begin
                    tile_done_cnt <= tile_done_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/write_addr_gen.sv */
//////////////////////////////
// Execute stage of the ping-pong controller
// Counts load beats and generates west and north write addresses
// Also tracks how many north columns are available for reading
//////////////////////////////

module write_addr_gen
    import pingpong_pkg::*;
#(
    parameter int W_COL          = 4,
    parameter int N_ROW          = 4,
    parameter int N_COL          = 4,
    parameter int INNER_DIM      = 4,
    parameter int BEATS_PER_LOAD = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  buf_state_e state,
    output west_bank_t w_wr0,
    output west_bank_t w_wr1,
    output logic       n_we,
    output n_addr_t    n_wr_addr,
    output logic       bank_full,
    output cnt_t       north_cols_ready
);

    // Blocks along the inner dimension of one row
    localparam int BLOCKS = INNER_DIM / BLOCK_SIZE;

    logic    burst_active;
    cnt_t    beat_cnt;
    logic    wr_fire;
    logic    wr_bank0;
    logic    wr_bank1;
    w_addr_t wr_idx;
    cnt_t    blk_cnt;

    // A beat only writes while a bank is in its write phase
    assign wr_fire  = burst_active && ((state == ST_W0_R1) || (state == ST_W1_R0));
    assign wr_bank0 = wr_fire && (state == ST_W0_R1);
    assign wr_bank1 = wr_fire && (state == ST_W1_R0);

    // Last beat of the bank, same cycle as the write
    assign bank_full = wr_fire && (wr_idx == w_addr_t'(W_COL - 1));

    // Port A takes the low half, port B the high half
    assign w_wr0.en     = wr_bank0;
    assign w_wr0.we_a   = wr_bank0;
    assign w_wr0.we_b   = wr_bank0;
    assign w_wr0.addr_a = wr_idx;
    assign w_wr0.addr_b = w_addr_t'(W_COL) + wr_idx;

    assign w_wr1.en     = wr_bank1;
    assign w_wr1.we_a   = wr_bank1;
    assign w_wr1.we_b   = wr_bank1;
    assign w_wr1.addr_a = wr_idx;
    assign w_wr1.addr_b = w_addr_t'(W_COL) + wr_idx;

    // North bank is written on every beat
    assign n_we = wr_fire;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            burst_active     <= 1'b0;
            beat_cnt         <= '0;
            wr_idx           <= '0;
            n_wr_addr        <= '0;
            blk_cnt          <= '0;
            north_cols_ready <= '0;
        end else begin
            // Burst window, first beat in the cycle after in_valid
            if (!burst_active) begin
                if (in_valid && (state != ST_DONE)) begin
                    burst_active <= 1'b1;
                    beat_cnt     <= '0;
                end
            end else if (beat_cnt == cnt_t'(BEATS_PER_LOAD - 1)) begin
                burst_active <= 1'b0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end

            if (wr_fire) begin
                // West index wraps when the bank is full
                if (bank_full) begin
                    wr_idx <= '0;
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
                // North address wraps at the end of the bank
                if (n_wr_addr == n_addr_t'(N_COL * N_ROW - 1)) begin
                    n_wr_addr <= '0;
                end else begin
                    n_wr_addr <= n_wr_addr + 1'b1;
                end
                // One more north column per row of blocks
                if (blk_cnt == cnt_t'(BLOCKS - 1)) begin
                    blk_cnt <= '0;
                    if (north_cols_ready < cnt_t'(N_ROW)) begin
                        north_cols_ready <= north_cols_ready + 1'b1;
                    end
                end else begin
                    blk_cnt <= blk_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/buf_phase_fsm.sv */
//////////////////////////////
// Decode stage of the ping-pong controller
// Phase FSM choosing which west bank is written and which is read
// Ends in ST_DONE once MAX_TILES output elements are finished
//////////////////////////////

module buf_phase_fsm
    import pingpong_pkg::*;
#(
    parameter int MAX_TILES = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  logic       bank_full,
    input  cnt_t       tile_done_cnt,
    output buf_state_e state
);

    buf_state_e state_next;
    logic       all_tiles_done;

    // Terminal count from the read sequencer
    assign all_tiles_done = (tile_done_cnt == cnt_t'(MAX_TILES));

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                // First burst always lands in bank 0
                if (in_valid) begin
                    state_next = ST_W0_R1;
                end
            end
            ST_W0_R1: begin
                // Termination wins over the bank swap
                if (all_tiles_done) begin
                    state_next = ST_DONE;
                end else if (bank_full) begin
                    state_next = ST_W1_R0;
                end
            end
            ST_W1_R0: begin
                if (all_tiles_done) begin
                    state_next = ST_DONE;
                end else if (bank_full) begin
                    state_next = ST_W0_R1;
                end
            end
            ST_DONE: begin
                // Held until reset
                state_next = ST_DONE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    // Phase register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* rtl/pingpong_pkg.sv */
//////////////////////////////
// Shared widths, types and port bundles for the ping-pong buffer controller
// Imported by every RTL stage and by the testbench
//////////////////////////////

package pingpong_pkg;

    // West bank address, port A low half and port B high half
    localparam int W_ADDR_WIDTH = 4;
    // North bank address, written and read on separate ports
    localparam int N_ADDR_WIDTH = 4;
    // Internal counters
    localparam int CNT_WIDTH    = 8;
    // Edge of one systolic block
    localparam int BLOCK_SIZE   = 2;

    typedef logic [W_ADDR_WIDTH-1:0] w_addr_t;
    typedef logic [N_ADDR_WIDTH-1:0] n_addr_t;
    typedef logic [CNT_WIDTH-1:0]    cnt_t;

    // Ping-pong phase, W = writing bank, R = reading bank
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_W0_R1,
        ST_W1_R0,
        ST_DONE
    } buf_state_e;

    // One west bank, dual port (11 bits)
    typedef struct packed {
        logic    en;
        logic    we_a;
        logic    we_b;
        w_addr_t addr_a;
        w_addr_t addr_b;
    } west_bank_t;

    // North bank, write on one port and read on the other (10 bits)
    typedef struct packed {
        logic    en;
        logic    we;
        n_addr_t wr_addr;
        n_addr_t rd_addr;
    } north_bank_t;

endpackage
